// ==== rtl/dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// two-way cache geometry
`define DC_SETS      8
`define DC_WORDS     2        // words per block

// address fields
`define DC_IDX_W     3        // addr[5:3]
`define DC_TAG_W     26       // addr[31:6]
`define DC_WORD_W    32

// hit count is written here at the end of a flush
`define DC_HIT_ADDR  32'h3100

`endif

// ==== rtl/dcache_pkg.sv ====
`include "dcache_defines.svh"

package dcache_pkg;

   typedef logic [`DC_WORD_W-1:0] word_t;   // data word or byte address
   typedef logic [`DC_TAG_W-1:0]  tag_t;
   typedef logic [`DC_IDX_W-1:0]  idx_t;
   typedef logic                  way_t;    // 0 or 1

   // controller states
   typedef enum logic [2:0]
   {
      IDLE,
      WB1,        // victim word 0 to memory
      WB2,        // victim word 1 to memory
      FILL1,      // other word of the block
      FILL2,      // requested word, store merged here
      FLUSH,
      HIT_WRITE,
      DONE
   } dc_state_t;

endpackage

// ==== rtl/dcache_array_if.sv ====
`timescale 1ns/1ps

interface dcache_array_if import dcache_pkg::*; ();

   // from the controller
   idx_t  idx;
   tag_t  tag;
   logic  word_sel;
   way_t  way;           // way being written or inspected
   logic  fill_we;
   logic  store_we;
   word_t wdata;
   logic  set_dirty;
   logic  make_valid;
   logic  touch;         // mark the other way as LRU
   logic  clear_dirty;

   // from the storage
   logic  hit;
   way_t  hit_way;
   way_t  victim_way;    // LRU way of idx
   logic  victim_valid;
   logic  victim_dirty;
   tag_t  victim_tag;
   word_t rdata_hit;
   word_t blk_word0;
   word_t blk_word1;

   modport ctrl (
      output idx, tag, word_sel, way, fill_we, store_we, wdata,
             set_dirty, make_valid, touch, clear_dirty,
      input  hit, hit_way, victim_way, victim_valid, victim_dirty,
             victim_tag, rdata_hit, blk_word0, blk_word1
   );

   modport array (
      input  idx, tag, word_sel, way, fill_we, store_we, wdata,
             set_dirty, make_valid, touch, clear_dirty,
      output hit, hit_way, victim_way, victim_valid, victim_dirty,
             victim_tag, rdata_hit, blk_word0, blk_word1
   );

endinterface

// ==== rtl/dcache_array.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_array import dcache_pkg::*;
(
   input logic           CLK,
   input logic           nRST,
   dcache_array_if.array bus
);

   logic  valid_q [2][`DC_SETS];
   logic  dirty_q [2][`DC_SETS];
   tag_t  tag_q   [2][`DC_SETS];
   word_t data_q  [2][`DC_SETS][`DC_WORDS];
   logic [`DC_SETS-1:0] lru_q;      // per set, the way to evict next

   logic [1:0] way_hit;

   // tag compare on both ways
   always_comb
   begin
      for (int w = 0; w < 2; w++)
      begin
         way_hit[w] = valid_q[w][bus.idx] && (tag_q[w][bus.idx] == bus.tag);
      end
   end

   assign bus.hit       = |way_hit;
   assign bus.hit_way   = way_t'(way_hit[1]);
   assign bus.rdata_hit = data_q[bus.hit_way][bus.idx][bus.word_sel];

   assign bus.victim_way = lru_q[bus.idx];

   // status and words of the way the controller points at
   // during a miss that is the victim, during flush the walked way
   assign bus.victim_valid = valid_q[bus.way][bus.idx];
   assign bus.victim_dirty = dirty_q[bus.way][bus.idx];
   assign bus.victim_tag   = tag_q[bus.way][bus.idx];
   assign bus.blk_word0    = data_q[bus.way][bus.idx][0];
   assign bus.blk_word1    = data_q[bus.way][bus.idx][1];

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         lru_q <= '0;
         for (int w = 0; w < 2; w++)
         begin
            for (int s = 0; s < `DC_SETS; s++)
            begin
               valid_q[w][s] <= 1'b0;
               dirty_q[w][s] <= 1'b0;
               tag_q[w][s]   <= '0;
               for (int k = 0; k < `DC_WORDS; k++)
                  data_q[w][s][k] <= '0;
            end
         end
      end
      else
      begin
         if (bus.fill_we)
         begin
            data_q[bus.way][bus.idx][bus.word_sel] <= bus.wdata;
            tag_q[bus.way][bus.idx]   <= bus.tag;
            dirty_q[bus.way][bus.idx] <= bus.set_dirty;   // set on a write miss
            if (bus.make_valid)
               valid_q[bus.way][bus.idx] <= 1'b1;
         end
         if (bus.store_we)
         begin
            data_q[bus.way][bus.idx][bus.word_sel] <= bus.wdata;
            dirty_q[bus.way][bus.idx] <= 1'b1;
         end
         if (bus.clear_dirty)
            dirty_q[bus.way][bus.idx] <= 1'b0;   // block is back in memory
         if (bus.touch)
            lru_q[bus.idx] <= ~bus.way;
      end
   end

endmodule

// ==== rtl/dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_ctrl import dcache_pkg::*;
(
   input  logic         CLK,
   input  logic         nRST,
   input  logic         dmem_ren,
   input  logic         dmem_wen,
   input  logic         halt,
   input  word_t        dmem_addr,
   input  word_t        dmem_store,
   output word_t        dmem_load,
   output logic         dhit,
   output logic         flushed,
   output logic         mem_ren,
   output logic         mem_wen,
   output word_t        mem_addr,
   output word_t        mem_store,
   input  word_t        mem_load,
   input  logic         mem_wait,
   dcache_array_if.ctrl bus
);

   dc_state_t state, next_state;

   tag_t req_tag;
   idx_t req_idx;
   logic req_word;
   logic req;

   // flush walker
   way_t fl_way, next_fl_way;
   idx_t fl_idx, next_fl_idx;
   logic fl_word, next_fl_word;
   logic fl_set_end;
   logic fl_last;

   word_t hit_cnt;
   logic  count_hit;

   assign req_tag  = dmem_addr[`DC_WORD_W-1 -: `DC_TAG_W];
   assign req_idx  = dmem_addr[2+`DC_IDX_W -: `DC_IDX_W];
   assign req_word = dmem_addr[2];
   assign req      = dmem_ren | dmem_wen;

   assign fl_set_end = (fl_idx == idx_t'(`DC_SETS-1));
   assign fl_last    = fl_set_end && (fl_way == 1'b1);

   // array lookup steering
   assign bus.idx = (state == FLUSH) ? fl_idx : req_idx;
   assign bus.tag = req_tag;
   assign bus.way = (state == FLUSH) ? fl_way :
                    (state == IDLE && bus.hit) ? bus.hit_way : bus.victim_way;
   assign bus.word_sel = (state == FLUSH) ? fl_word :
                         (state == FILL1) ? ~req_word : req_word;

   always_comb
   begin
      next_state   = state;
      next_fl_way  = fl_way;
      next_fl_idx  = fl_idx;
      next_fl_word = fl_word;
      count_hit    = 1'b0;

      dhit      = 1'b0;
      dmem_load = '0;
      flushed   = 1'b0;
      mem_ren   = 1'b0;
      mem_wen   = 1'b0;
      mem_addr  = '0;
      mem_store = '0;

      bus.wdata       = dmem_store;
      bus.fill_we     = 1'b0;
      bus.store_we    = 1'b0;
      bus.set_dirty   = 1'b0;
      bus.make_valid  = 1'b0;
      bus.touch       = 1'b0;
      bus.clear_dirty = 1'b0;

      case (state)
         IDLE:
         begin
            if (halt)
               next_state = FLUSH;
            else if (req && bus.hit)
            begin
               dhit         = 1'b1;
               dmem_load    = bus.rdata_hit;
               bus.store_we = dmem_wen;
               bus.touch    = 1'b1;
               count_hit    = 1'b1;
            end
            else if (req)
               next_state = (bus.victim_valid && bus.victim_dirty) ? WB1 : FILL1;
         end
         WB1:
         begin
            mem_wen   = 1'b1;
            mem_addr  = {bus.victim_tag, req_idx, 1'b0, 2'b00};
            mem_store = bus.blk_word0;
            if (!mem_wait)
               next_state = WB2;
         end
         WB2:
         begin
            mem_wen   = 1'b1;
            mem_addr  = {bus.victim_tag, req_idx, 1'b1, 2'b00};
            mem_store = bus.blk_word1;
            if (!mem_wait)
            begin
               bus.clear_dirty = 1'b1;
               next_state      = FILL1;
            end
         end
         FILL1:
         begin
            // the word not asked for comes first
            mem_ren   = 1'b1;
            mem_addr  = {req_tag, req_idx, ~req_word, 2'b00};
            bus.wdata = mem_load;
            if (!mem_wait)
            begin
               bus.fill_we = 1'b1;
               next_state  = FILL2;
            end
         end
         FILL2:
         begin
            mem_ren   = 1'b1;
            mem_addr  = {req_tag, req_idx, req_word, 2'b00};
            bus.wdata = dmem_wen ? dmem_store : mem_load;   // store merge
            if (!mem_wait)
            begin
               bus.fill_we    = 1'b1;
               bus.make_valid = 1'b1;
               bus.set_dirty  = dmem_wen;
               bus.touch      = 1'b1;
               dhit           = 1'b1;
               dmem_load      = mem_load;
               next_state     = IDLE;
            end
         end
         FLUSH:
         begin
            if (bus.victim_dirty)
            begin
               mem_wen   = 1'b1;
               mem_addr  = {bus.victim_tag, fl_idx, fl_word, 2'b00};
               mem_store = fl_word ? bus.blk_word1 : bus.blk_word0;
            end
            if (!bus.victim_dirty || (!mem_wait && fl_word))
            begin
               // block finished, step to next set
               bus.clear_dirty = bus.victim_dirty;
               next_fl_word    = 1'b0;
               next_fl_idx     = fl_idx + 1'b1;
               if (fl_set_end)
                  next_fl_way = ~fl_way;
               if (fl_last)
                  next_state = HIT_WRITE;
            end
            else if (!mem_wait)
               next_fl_word = 1'b1;
         end
         HIT_WRITE:
         begin
            mem_wen   = 1'b1;
            mem_addr  = `DC_HIT_ADDR;
            mem_store = hit_cnt;
            if (!mem_wait)
               next_state = DONE;
         end
         DONE:
            flushed = 1'b1;   // held until reset
         default:
            next_state = IDLE;
      endcase
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state   <= IDLE;
         fl_way  <= 1'b0;
         fl_idx  <= '0;
         fl_word <= 1'b0;
         hit_cnt <= '0;
      end
      else
      begin
         state   <= next_state;
         fl_way  <= next_fl_way;
         fl_idx  <= next_fl_idx;
         fl_word <= next_fl_word;
         if (count_hit)
            hit_cnt <= hit_cnt + 1'b1;
      end
   end

endmodule

// ==== rtl/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*;
(
   input  logic  CLK,
   input  logic  nRST,
   // datapath side
   input  logic  dmem_ren,
   input  logic  dmem_wen,
   input  logic  halt,
   input  word_t dmem_addr,
   input  word_t dmem_store,
   output word_t dmem_load,
   output logic  dhit,
   output logic  flushed,
   // memory side
   output logic  mem_ren,
   output logic  mem_wen,
   output word_t mem_addr,
   output word_t mem_store,
   input  word_t mem_load,
   input  logic  mem_wait
);

   dcache_array_if bus ();

   dcache_array u_array (
      .CLK  (CLK),
      .nRST (nRST),
      .bus  (bus.array)
   );

   dcache_ctrl u_ctrl (
      .CLK        (CLK),
      .nRST       (nRST),
      .dmem_ren   (dmem_ren),
      .dmem_wen   (dmem_wen),
      .halt       (halt),
      .dmem_addr  (dmem_addr),
      .dmem_store (dmem_store),
      .dmem_load  (dmem_load),
      .dhit       (dhit),
      .flushed    (flushed),
      .mem_ren    (mem_ren),
      .mem_wen    (mem_wen),
      .mem_addr   (mem_addr),
      .mem_store  (mem_store),
      .mem_load   (mem_load),
      .mem_wait   (mem_wait),
      .bus        (bus.ctrl)
   );

endmodule

// ==== tb/dcache_checker.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_checker import dcache_pkg::*;
(
   input  logic  CLK,
   input  logic  nRST,
   input  logic  dmem_ren,
   input  logic  dmem_wen,
   input  logic  halt,
   input  word_t dmem_addr,
   input  word_t dmem_store,
   input  word_t dmem_load,
   input  logic  dhit,
   input  logic  flushed,
   input  logic  mem_ren,
   input  logic  mem_wen,
   input  word_t mem_addr,
   input  word_t mem_store,
   input  logic  mem_wait,
   input  word_t exp_load,    // load column of the current line
   input  int    exp_hits,
   output int    load_errs,
   output int    mem_errs,
   output int    ctrl_errs,
   output logic  final_done
);

   localparam int DEPTH = 4096;   // same span as the memory model

   word_t ref_mem  [DEPTH];   // flat reference updated on store dhit
   word_t seen_mem [DEPTH];   // rebuilt from completed memory writes
   logic  hit_seen;
   word_t hit_word;
   logic  flushed_q;

   function automatic int word_idx(input word_t a);
      return int'(a[13:2]);
   endfunction

   task automatic final_compare();
      for (int i = 0; i < DEPTH; i++)
      begin
         if (i != word_idx(`DC_HIT_ADDR) && seen_mem[i] !== ref_mem[i])
         begin
            $display("** Error at %0t: mem[%h] = %h, expected %h",
                     $time, i << 2, seen_mem[i], ref_mem[i]);
            mem_errs++;
         end
      end
      if (!hit_seen)
      begin
         $display("hit count word was never written before flushed rose");
         mem_errs++;
      end
      else if (hit_word !== word_t'(exp_hits))
      begin
         $display("** Error at %0t: hit count = %0d, expected %0d", $time, hit_word, exp_hits);
         mem_errs++;
      end
   endtask

   always @(negedge CLK)
   begin
      if (!nRST)
      begin
         for (int i = 0; i < DEPTH; i++)
         begin
            ref_mem[i]  = word_t'(i) << 2;
            seen_mem[i] = word_t'(i) << 2;
         end
         load_errs  = 0;
         mem_errs   = 0;
         ctrl_errs  = 0;
         hit_seen   = 1'b0;
         hit_word   = '0;
         flushed_q  = 1'b0;
         final_done = 1'b0;
      end
      else
      begin
         if (dhit && halt)
         begin
            $display("dhit came at %0t while halt was high", $time);
            ctrl_errs++;
         end
         if (dhit && dmem_ren)
         begin
            if (dmem_load !== exp_load)
            begin
               $display("** Error at %0t: dmem_load = %h, expected %h",
                        $time, dmem_load, exp_load);
               load_errs++;
            end
            if (dmem_load !== ref_mem[word_idx(dmem_addr)])
            begin
               $display("** Error at %0t: dmem_load = %h, expected %h from reference",
                        $time, dmem_load, ref_mem[word_idx(dmem_addr)]);
               load_errs++;
            end
         end
         if (dhit && dmem_wen)
            ref_mem[word_idx(dmem_addr)] = dmem_store;

         // a write lands in the cycle with mem_wait low
         if (mem_wen && !mem_wait)
         begin
            if (mem_addr == `DC_HIT_ADDR)
            begin
               hit_seen = 1'b1;
               hit_word = mem_store;
            end
            else
               seen_mem[word_idx(mem_addr)] = mem_store;
         end

         if (flushed && (mem_ren || mem_wen))
         begin
            $display("memory access at %0t after flushed rose", $time);
            ctrl_errs++;
         end
         if (flushed && !flushed_q)
         begin
            final_compare();
            final_done = 1'b1;
         end
         if (!flushed && flushed_q)
         begin
            $display("flushed dropped at %0t before reset", $time);
            ctrl_errs++;
         end
         flushed_q = flushed;
      end
   end

endmodule

// ==== tb/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

   localparam int MAX_LINES  = 64;
   localparam int MEM_WORDS  = 4096;   // 16 KB model indexed by addr[13:2]
   localparam int ACCESS_MAX = 6;      // arm, up to 3 waits, wait low, idle
   localparam int MARGIN     = 100;

   logic  CLK;
   logic  nRST;
   logic  dmem_ren;
   logic  dmem_wen;
   logic  halt;
   word_t dmem_addr;
   word_t dmem_store;
   word_t dmem_load;
   logic  dhit;
   logic  flushed;
   logic  mem_ren;
   logic  mem_wen;
   word_t mem_addr;
   word_t mem_store;
   word_t mem_load = '0;
   logic  mem_wait = 1'b1;

   word_t stim [MAX_LINES*5];   // op, addr, store, load, hit per line
   word_t mem  [MEM_WORDS];
   word_t exp_load;
   int    exp_hits;
   int    n_lines;
   int    limit = 1000000;
   int    cycles = 0;
   int    load_errs;
   int    mem_errs;
   int    ctrl_errs;
   logic  final_done;

   logic [31:0] lfsr;
   logic [1:0]  wait_cnt;
   logic        armed;

   dcache_top dut (
      .CLK        (CLK),
      .nRST       (nRST),
      .dmem_ren   (dmem_ren),
      .dmem_wen   (dmem_wen),
      .halt       (halt),
      .dmem_addr  (dmem_addr),
      .dmem_store (dmem_store),
      .dmem_load  (dmem_load),
      .dhit       (dhit),
      .flushed    (flushed),
      .mem_ren    (mem_ren),
      .mem_wen    (mem_wen),
      .mem_addr   (mem_addr),
      .mem_store  (mem_store),
      .mem_load   (mem_load),
      .mem_wait   (mem_wait)
   );

   dcache_checker chk (
      .CLK        (CLK),
      .nRST       (nRST),
      .dmem_ren   (dmem_ren),
      .dmem_wen   (dmem_wen),
      .halt       (halt),
      .dmem_addr  (dmem_addr),
      .dmem_store (dmem_store),
      .dmem_load  (dmem_load),
      .dhit       (dhit),
      .flushed    (flushed),
      .mem_ren    (mem_ren),
      .mem_wen    (mem_wen),
      .mem_addr   (mem_addr),
      .mem_store  (mem_store),
      .mem_wait   (mem_wait),
      .exp_load   (exp_load),
      .exp_hits   (exp_hits),
      .load_errs  (load_errs),
      .mem_errs   (mem_errs),
      .ctrl_errs  (ctrl_errs),
      .final_done (final_done)
   );

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // line count, hit total and run limit from the loaded stimulus
   task automatic scan_stim();
      n_lines  = 0;
      exp_hits = 0;
      while (n_lines < MAX_LINES && stim[5*n_lines] != 32'd2)
      begin
         exp_hits += int'(stim[5*n_lines+4]);
         n_lines++;
      end
      // each line at worst two write-backs and two fills, then the flush
      limit = 8 + n_lines * (4 * ACCESS_MAX + 2)
            + 8 * 2 * (2 * ACCESS_MAX + 1) + ACCESS_MAX + MARGIN;
   endtask

   initial
   begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   // memory model with a random wait per access
   always @(posedge CLK or negedge nRST)
   begin : mem_model
      logic [31:0] step_a;
      logic [31:0] step_b;
      if (!nRST)
      begin
         for (int i = 0; i < MEM_WORDS; i++)
            mem[i] <= word_t'(i) << 2;   // each word holds its own address
         lfsr     <= 32'hc533a30a;
         mem_wait <= 1'b1;
         mem_load <= '0;
         armed    <= 1'b0;
         wait_cnt <= '0;
      end
      else if (!mem_wait)
      begin
         if (mem_wen)
            mem[mem_addr[13:2]] <= mem_store;
         mem_wait <= 1'b1;              // access done
      end
      else if (mem_ren || mem_wen)
      begin
         if (!armed)
         begin
            step_a = lfsr_step(lfsr);   // one step per bit
            step_b = lfsr_step(step_a);
            wait_cnt <= {step_a[0], step_b[0]};
            lfsr     <= step_b;
            armed    <= 1'b1;
         end
         else if (wait_cnt == 2'd0)
         begin
            mem_load <= mem[mem_addr[13:2]];
            mem_wait <= 1'b0;
            armed    <= 1'b0;
         end
         else
            wait_cnt <= wait_cnt - 1'b1;
      end
   end

   always @(posedge CLK)
   begin
      cycles <= cycles + 1;
      if (cycles >= limit)
      begin
         $display("timeout after %0d cycles, the run never reached flushed", cycles);
         $display("TB FAILED");
         $finish;
      end
   end

   initial
   begin
      nRST       = 1'b0;
      dmem_ren   = 1'b0;
      dmem_wen   = 1'b0;
      halt       = 1'b0;
      dmem_addr  = '0;
      dmem_store = '0;
      exp_load   = '0;
      for (int i = 0; i < MAX_LINES*5; i++)
         stim[i] = '1;
      $readmemh("tb/dcache_stim.txt", stim);
      scan_stim();

      repeat (8) @(posedge CLK);
      nRST <= 1'b1;

      for (int i = 0; i < n_lines; i++)
      begin
         @(posedge CLK);
         dmem_ren   <= (stim[5*i] == 32'd0);
         dmem_wen   <= (stim[5*i] == 32'd1);
         dmem_addr  <= stim[5*i+1];
         dmem_store <= stim[5*i+2];
         exp_load   <= stim[5*i+3];
         @(negedge CLK);
         while (!dhit)
            @(negedge CLK);
      end

      @(posedge CLK);
      halt <= 1'b1;   // halt outranks the request still held
      while (!final_done)
         @(negedge CLK);
      repeat (4) @(posedge CLK);   // flushed has to hold

      $display("errors: %0d load, %0d memory, %0d control", load_errs, mem_errs, ctrl_errs);
      if (load_errs + mem_errs + ctrl_errs == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// ==== tb/dcache_stim.txt ====
// op addr store expected_load expected_hit, all hex
// op 0 load, 1 store, 2 halt; store lines carry a zero load value
0 00000000 00000000 00000000 0
0 00000004 00000000 00000004 1
1 00000004 a5a50004 00000000 1
0 00000004 00000000 a5a50004 1
1 00000010 11110010 00000000 0
0 00000014 00000000 00000014 1
// set 1 gets three tags, dirty victims written back
1 00000008 dead0008 00000000 0
1 0000004c beef004c 00000000 0
0 0000008c 00000000 0000008c 0
0 00000008 00000000 dead0008 0
0 00000048 00000000 00000048 0
0 0000004c 00000000 beef004c 1
1 0000000c 0c0c0c0c 00000000 1
0 000001f8 00000000 000001f8 0
1 000001fc 77770000 00000000 1
// set 0 filled with far tags, dirty block written back
0 00002000 00000000 00002000 0
0 00003000 00000000 00003000 0
0 00000004 00000000 a5a50004 0
0 00000010 00000000 11110010 1
2 00000000 00000000 00000000 0

// ==== filelist.f ====
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_array_if.sv
rtl/dcache_array.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
tb/dcache_checker.sv
tb/tb_dcache.sv

// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_dcache
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
SIM        = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
